//--- bench/exec_vectors.txt
# name instr rs_val rt_val pc pc1 value dest branch_target flags, all hex after the name
# flags hold reg_write, mem_read and mem_write from the high bit down
add_rr      00221820 00000005 00000007 04 05 0000000c 03 04 4
sub_neg     00221822 00000003 00000008 06 07 fffffffb 03 08 4
and_rr      00221824 f0f0f0f0 0ff00ff0 0a 0b 00f000f0 03 0e 4
or_rr       00221825 f0f0f0f0 0ff00ff0 0c 0d fff0fff0 03 11 4
xor_rr      00221826 f0f0f0f0 0ff00ff0 10 11 ff00ff00 03 16 4
nor_rr      00221827 0000ff00 00ff0000 12 13 ff0000ff 03 19 4
slt_neg     0022182a fffffffe 00000001 14 15 00000001 03 1e 4
slt_false   0022182a 00000005 fffffff0 1e 1f 00000000 03 08 4
sll_imm     00021900 deadbeef 00000013 01 02 00000130 03 01 4
srl_imm     00021a02 deadbeef 80000000 03 04 00800000 03 05 4
sra_imm     00021a03 deadbeef 80000000 05 06 ff800000 03 08 4
addi_neg    2024fffc 00000010 00000000 07 08 0000000c 04 03 4
andi_zext   302400ff abcd1234 00000000 08 09 00000034 04 07 4
ori_zext    34248001 00010000 00000000 09 0a 00018001 04 0a 4
lui_imm     3c041234 deadbeef 00000000 0b 0c 12340000 04 1f 4
lw_base     8c25fff8 00001000 00000000 0d 0e 00000ff8 05 05 6
sw_base     ac260010 00002000 cafef00d 0f 10 00002010 06 1f 1
beq_fwd     10220006 00000009 00000009 11 12 00000000 00 17 0
beq_wrap    1022fffd 00000005 00000007 04 05 fffffffe 1f 01 0
jal_link    0c000029 00000000 00000000 18 19 00000000 1f 01 4
unknown_op  fc221820 00000001 00000002 1a 1b 00000003 03 1a 0
fadd_pos    460208c0 3fc00000 40100000 13 14 40700000 03 13 4
fadd_opp    460208c0 40a00000 bfa00000 15 16 40700000 03 15 4
fadd_cancel 460208c0 40200000 c0200000 17 18 00000000 03 17 4
fadd_negbig 460208c0 c0c00000 3fc00000 19 1a c0900000 03 19 4
fadd_trunc  460208c0 3f800000 33c00000 1b 1c 3f800000 03 1b 4
fmul_pos    460208c2 3fc00000 40200000 1c 1d 40700000 03 1e 4
fmul_carry  460208c2 c0400000 40400000 1d 1e c1100000 03 1f 4
fmul_zero   460208c2 00000000 40a00000 1e 1f 00000000 03 00 4
fmul_frac   460208c2 3f000000 3f400000 1f 00 3ec00000 03 01 4

//--- sim.f
common/arith_pkg.sv
common/stage_pkg.sv
design/decoder.sv
execution/operand_select.sv
execution/alu.sv
execution/fpu.sv
execution/execution.sv
design/exec_top.sv
bench/exec_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exec_tb \
	-f sim.f --Mdir obj_dir -o exec_tb_sim

./obj_dir/exec_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
	exit 0
fi
exit 1

//--- bench/exec_tb.sv
`default_nettype none

module exec_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int pc_width = 5;
	localparam int cycle_ns = 4;
	localparam int half_ns = 2;

	// One line of the vector file
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
		logic [pc_width-1:0] pc;
		logic [pc_width-1:0] pc1;
		logic [31:0] value;
		logic [4:0] dest;
		logic [pc_width-1:0] target;
		logic [2:0] flags;
	} vector_t;

	logic CLK;
	logic reset;
	logic issue;
	logic [31:0] instr;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [pc_width-1:0] pc;
	logic [pc_width-1:0] pc1;
	logic busy;
	logic valid;
	stage_pkg::exec_result_t result;
	logic [pc_width-1:0] pc_next;
	logic [pc_width-1:0] pc1_next;
	logic [pc_width-1:0] branch_target;

	vector_t vectors[$];
	string names[$];
	logic loaded;
	int unsigned seed;

	exec_top #(
		.pc_width(pc_width)
	) i_exec_top (
		.CLK(CLK),
		.reset(reset),
		.issue(issue),
		.instr(instr),
		.rs_val(rs_val),
		.rt_val(rt_val),
		.pc(pc),
		.pc1(pc1),
		.busy(busy),
		.valid(valid),
		.result(result),
		.pc_next(pc_next),
		.pc1_next(pc1_next),
		.branch_target(branch_target)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#half_ns CLK = ~CLK;
		end
	end

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic stop_failed();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		$display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, act);
		stop_failed();
	endtask

	task automatic check_level(input string name, input string what,
			input logic exp, input logic act);
		if (act !== exp) begin
			report_mismatch(name, what, 32'(exp), 32'(act));
		end
	endtask

	task automatic check_branch(input string name, input logic [1:0] exp,
			input logic [1:0] act);
		if (act !== exp) begin
			report_mismatch(name, "ctrl.branch", 32'(exp), 32'(act));
		end
	endtask

	task automatic check_pc(input string name, input string what,
			input logic [pc_width-1:0] exp, input logic [pc_width-1:0] act);
		if (act !== exp) begin
			report_mismatch(name, what, 32'(exp), 32'(act));
		end
	endtask

	task automatic check_result(input string name, input stage_pkg::exec_result_t exp,
			input stage_pkg::exec_result_t act);
		if (act.value !== exp.value) begin
			report_mismatch(name, "value", exp.value, act.value);
		end
		if (act.store_data !== exp.store_data) begin
			report_mismatch(name, "store_data", exp.store_data, act.store_data);
		end
		if (act.dest !== exp.dest) begin
			report_mismatch(name, "dest", 32'(exp.dest), 32'(act.dest));
		end
		if (act.inst_index !== exp.inst_index) begin
			report_mismatch(name, "inst_index", 32'(exp.inst_index), 32'(act.inst_index));
		end
		check_level(name, "ctrl.reg_write", exp.ctrl.reg_write, act.ctrl.reg_write);
		check_level(name, "ctrl.mem_read", exp.ctrl.mem_read, act.ctrl.mem_read);
		check_level(name, "ctrl.mem_write", exp.ctrl.mem_write, act.ctrl.mem_write);
	endtask

	task automatic read_vectors();
		int fd;
		int got;
		string line;
		logic [8*32-1:0] name_bits;
		logic [31:0] col [9];
		vector_t v;
		fd = $fopen("bench/exec_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file bench/exec_vectors.txt");
			stop_failed();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.substr(0, 0) == "#") begin
				continue;
			end
			got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name_bits, col[0], col[1],
				col[2], col[3], col[4], col[5], col[6], col[7], col[8]);
			if (got != 10) begin
				$display("Malformed line in the vector file: %s", line);
				stop_failed();
			end
			v.instr = col[0];
			v.rs_val = col[1];
			v.rt_val = col[2];
			v.pc = col[3][pc_width-1:0];
			v.pc1 = col[4][pc_width-1:0];
			v.value = col[5];
			v.dest = col[6][4:0];
			v.target = col[7][pc_width-1:0];
			v.flags = col[8][2:0];
			vectors.push_back(v);
			names.push_back(string'(name_bits));
		end
		$fclose(fd);
		if (vectors.size() == 0) begin
			$display("The vector file holds no vectors");
			stop_failed();
		end
	endtask

	task automatic run_vector(input string name, input vector_t v);
		stage_pkg::exec_result_t exp;
		logic fp;
		int gap;
		int cycles;
		logic seen;
		fp = (v.instr[31:26] == 6'h11);
		seed = lcg_next(seed);
		gap = int'((seed >> 16) % 4);
		repeat (gap) @(posedge CLK);
		@(negedge CLK);
		while (busy) begin
			@(negedge CLK);
		end
		@(posedge CLK);
		issue <= 1'b1;
		instr <= v.instr;
		rs_val <= v.rs_val;
		rt_val <= v.rt_val;
		pc <= v.pc;
		pc1 <= v.pc1;
		// Instruction is taken at this edge
		@(posedge CLK);
		issue <= 1'b0;
		cycles = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge CLK);
			cycles++;
			if (valid) begin
				seen = 1'b1;
			end else if (cycles > 10) begin
				$display("No valid from the execute stage within 10 cycles in test %s", name);
				stop_failed();
			end else if (fp) begin
				check_level(name, "busy before valid", 1'b1, busy);
			end
		end
		if (!fp && cycles != 2) begin
			report_mismatch(name, "valid latency", 32'd2, 32'(cycles));
		end
		exp = '0;
		exp.ctrl.reg_write = v.flags[2];
		exp.ctrl.mem_read = v.flags[1];
		exp.ctrl.mem_write = v.flags[0];
		exp.value = v.value;
		exp.store_data = v.rt_val;
		exp.dest = v.dest;
		exp.inst_index = v.instr[25:0];
		check_level(name, "busy at valid", 1'b0, busy);
		check_result(name, exp, result);
		check_pc(name, "branch_target", v.target, branch_target);
		check_pc(name, "pc_next", v.pc, pc_next);
		check_pc(name, "pc1_next", v.pc1, pc1_next);
		@(negedge CLK);
		check_level(name, "valid after pulse", 1'b0, valid);
	endtask

	initial begin
		reset = 1'b1;
		issue = 1'b0;
		instr = '0;
		rs_val = '0;
		rt_val = '0;
		pc = '0;
		pc1 = '0;
		loaded = 1'b0;
		seed = 14;
		read_vectors();
		loaded = 1'b1;
		repeat (10) @(posedge CLK);
		reset <= 1'b0;
		@(negedge CLK);
		check_level("after_reset", "valid", 1'b0, valid);
		check_level("after_reset", "busy", 1'b0, busy);
		check_branch("after_reset", 2'd3, result.ctrl.branch);
		foreach (vectors[i]) begin
			run_vector(names[i], vectors[i]);
		end
		$display("Testbench passed");
		$finish;
	end

	// Watchdog sized from the vector count
	initial begin
		wait (loaded);
		#((vectors.size() * 12 + 40) * cycle_ns);
		$display("Timeout: the run took longer than the vector set allows");
		stop_failed();
	end

endmodule

`default_nettype wire

//--- design/exec_top.sv
`default_nettype none

module exec_top #(
	parameter int pc_width = 5
) (
	input logic CLK,
	input logic reset,
	input logic issue,
	input logic [31:0] instr,
	input logic [31:0] rs_val,
	input logic [31:0] rt_val,
	input logic [pc_width-1:0] pc,
	input logic [pc_width-1:0] pc1,
	output logic busy,
	output logic valid,
	output stage_pkg::exec_result_t result,
	output logic [pc_width-1:0] pc_next,
	output logic [pc_width-1:0] pc1_next,
	output logic [pc_width-1:0] branch_target
);
	stage_pkg::issue_t dec;

	decoder #(
		.pc_width(pc_width)
	) i_decoder (
		.instr(instr),
		.rs_val(rs_val),
		.rt_val(rt_val),
		.dec(dec)
	);

	execution #(
		.pc_width(pc_width)
	) i_execution (
		.CLK(CLK),
		.reset(reset),
		.issue(issue),
		.dec(dec),
		.pc(pc),
		.pc1(pc1),
		.busy(busy),
		.valid(valid),
		.result(result),
		.pc_next(pc_next),
		.pc1_next(pc1_next),
		.branch_target(branch_target)
	);

endmodule

`default_nettype wire

//--- execution/execution.sv
`default_nettype none

module execution #(
	parameter int pc_width = 5
) (
	input logic CLK,
	input logic reset,
	input logic issue,
	input stage_pkg::issue_t dec,
	input logic [pc_width-1:0] pc,
	input logic [pc_width-1:0] pc1,
	output logic busy,
	output logic valid,
	output stage_pkg::exec_result_t result,
	output logic [pc_width-1:0] pc_next,
	output logic [pc_width-1:0] pc1_next,
	output logic [pc_width-1:0] branch_target
);
	typedef enum logic {
		st_idle,
		st_wait_fpu
	} state_e;

	state_e state;
	stage_pkg::issue_t iss_q;
	logic [pc_width-1:0] pc_q;
	logic [pc_width-1:0] pc1_q;
	logic take;
	logic alu_pend;
	logic fpu_start;
	logic fpu_done;
	logic finish;
	logic [31:0] op1;
	logic [31:0] op2;
	logic [4:0] dest;
	logic [31:0] alu_y;
	logic [31:0] fpu_y;
	logic [31:0] fin_value;

	assign busy = (state == st_wait_fpu);
	assign take = issue && !busy;
	// Integer work completes one edge after issue, FP work on done
	assign finish = alu_pend || (busy && fpu_done);
	assign fin_value = busy ? fpu_y : alu_y;

	operand_select i_operand_select (
		.dec(iss_q),
		.op1(op1),
		.op2(op2),
		.dest(dest)
	);

	alu i_alu (
		.op(iss_q.ctrl.alu_op),
		.a(op1),
		.b(op2),
		.y(alu_y)
	);

	fpu i_fpu (
		.CLK(CLK),
		.reset(reset),
		.start(fpu_start),
		.op(arith_pkg::fp_op_e'(iss_q.ctrl.alu_op[0])),
		.a(op1),
		.b(op2),
		.done(fpu_done),
		.y(fpu_y)
	);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= st_idle;
			valid <= 1'b0;
			alu_pend <= 1'b0;
			fpu_start <= 1'b0;
			result <= '{ctrl: stage_pkg::ctrl_nop, default: '0};
		end else begin
			valid <= finish;
			alu_pend <= take && !dec.ctrl.is_fp;
			fpu_start <= take && dec.ctrl.is_fp;
			if (finish) begin
				result <= '{
					ctrl: iss_q.ctrl,
					value: fin_value,
					store_data: iss_q.rt_val,
					dest: dest,
					inst_index: iss_q.inst_index
				};
			end
			case (state)
				st_idle: begin
					if (take && dec.ctrl.is_fp) begin
						state <= st_wait_fpu;
					end
				end
				default: begin
					if (fpu_done) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// Issued instruction and counters, held until the result leaves
	always_ff @(posedge CLK) begin
		if (take) begin
			iss_q <= dec;
			pc_q <= pc;
			pc1_q <= pc1;
		end
		if (finish) begin
			pc_next <= pc_q;
			pc1_next <= pc1_q;
			branch_target <= pc_q + iss_q.immediate[pc_width-1:0];
		end
	end

	a_no_issue_busy: assert property (@(posedge CLK) disable iff (reset) busy |-> !issue)
		else $error("issue while the execute stage is busy");

	// FPU done only arrives while the stage waits for it
	a_done_in_wait: assert property (
		@(posedge CLK) disable iff (reset) fpu_done |-> busy
	) else $error("FPU done outside the wait state");

endmodule

`default_nettype wire

//--- execution/fpu.sv
`default_nettype none

module fpu (
	input logic CLK,
	input logic reset,
	input logic start,
	input arith_pkg::fp_op_e op,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic done,
	output logic [31:0] y
);
	localparam int exp_w = arith_pkg::EXP_W;
	localparam int man_w = arith_pkg::MAN_W;
	localparam int man_full = man_w + 1;
	localparam int prod_w = 2 * man_full;
	localparam int ew = exp_w + 2;
	localparam int lz_w = $clog2(man_full + 1);
	localparam int bias = (1 << (exp_w - 1)) - 1;
	localparam int sign_bit = exp_w + man_w;

	function automatic logic [lz_w-1:0] lead_zeros(input logic [man_full-1:0] v);
		logic [lz_w-1:0] n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = man_full - 1; i >= 0; i--) begin
			if (!found) begin
				if (v[i]) begin
					found = 1'b1;
				end else begin
					n = n + 1'b1;
				end
			end
		end
		return n;
	endfunction

	// Zero and underflow both come out as +0
	function automatic logic [31:0] pack(
		input logic sign,
		input logic signed [ew-1:0] e,
		input logic [man_w-1:0] frac,
		input logic zero
	);
		if (zero || e <= 0) begin
			return '0;
		end
		return {sign, e[exp_w-1:0], frac};
	endfunction

	logic v1;
	logic v2;
	logic v3;
	arith_pkg::fp_op_e op_q;
	logic [exp_w-1:0] exp_a;
	logic [exp_w-1:0] exp_b;
	logic [man_full-1:0] man_a;
	logic [man_full-1:0] man_b;
	logic a_big;
	logic [exp_w-1:0] exp_diff;
	logic [man_full-1:0] s1_man_x;
	logic [man_full-1:0] s1_man_y;
	logic signed [ew-1:0] s1_exp;
	logic s1_sign;
	logic s1_sub;
	logic s1_zero;
	logic [prod_w-1:0] s2_prod;
	logic [man_full:0] s2_sum;
	logic signed [ew-1:0] s2_exp;
	logic s2_sign;
	logic s2_zero;
	logic [lz_w-1:0] add_lz;
	logic [man_full-1:0] add_shift;
	logic [man_w-1:0] mul_frac;
	logic signed [ew-1:0] mul_exp;
	logic [man_w-1:0] add_frac;
	logic signed [ew-1:0] add_exp;
	logic [man_w-1:0] s3_frac;
	logic signed [ew-1:0] s3_exp;
	logic s3_sign;
	logic s3_zero;

	always_comb begin
		exp_a = a[man_w +: exp_w];
		exp_b = b[man_w +: exp_w];
		// Denormals flush, so a zero exponent has no hidden bit
		man_a = (exp_a == '0) ? '0 : {1'b1, a[man_w-1:0]};
		man_b = (exp_b == '0) ? '0 : {1'b1, b[man_w-1:0]};
		a_big = a[sign_bit-1:0] >= b[sign_bit-1:0];
		exp_diff = a_big ? exp_a - exp_b : exp_b - exp_a;
	end

	always_comb begin
		if (s2_prod[prod_w-1]) begin
			mul_frac = s2_prod[prod_w-2 -: man_w];
			mul_exp = s2_exp + 1;
		end else begin
			mul_frac = s2_prod[prod_w-3 -: man_w];
			mul_exp = s2_exp;
		end
		add_lz = lead_zeros(s2_sum[man_full-1:0]);
		add_shift = s2_sum[man_full-1:0] << add_lz;
		if (s2_sum[man_full]) begin
			add_frac = s2_sum[man_full-1 -: man_w];
			add_exp = s2_exp + 1;
		end else begin
			add_frac = add_shift[man_w-1:0];
			add_exp = s2_exp - $signed({1'b0, add_lz});
		end
	end

	always_ff @(posedge CLK) begin
		if (start) begin
			op_q <= op;
		end
		// Stage 1 unpack, align for add
		if (op == arith_pkg::fp_mul) begin
			s1_man_x <= man_a;
			s1_man_y <= man_b;
			s1_exp <= ew'(int'(exp_a) + int'(exp_b) - bias);
			s1_sign <= a[sign_bit] ^ b[sign_bit];
		end else if (a_big) begin
			s1_man_x <= man_a;
			s1_man_y <= man_b >> exp_diff;
			s1_exp <= ew'(exp_a);
			s1_sign <= a[sign_bit];
		end else begin
			s1_man_x <= man_b;
			s1_man_y <= man_a >> exp_diff;
			s1_exp <= ew'(exp_b);
			s1_sign <= b[sign_bit];
		end
		s1_sub <= a[sign_bit] ^ b[sign_bit];
		s1_zero <= (exp_a == '0) || (exp_b == '0);
		// Stage 2 mantissa arithmetic
		s2_prod <= prod_w'(s1_man_x) * prod_w'(s1_man_y);
		if (s1_sub) begin
			s2_sum <= {1'b0, s1_man_x} - {1'b0, s1_man_y};
		end else begin
			s2_sum <= {1'b0, s1_man_x} + {1'b0, s1_man_y};
		end
		s2_exp <= s1_exp;
		s2_sign <= s1_sign;
		s2_zero <= s1_zero;
		// Stage 3 normalize the sum
		s3_frac <= add_frac;
		s3_exp <= add_exp;
		s3_sign <= s2_sign;
		s3_zero <= (s2_sum == '0);
		if (v2 && op_q == arith_pkg::fp_mul) begin
			y <= pack(s2_sign, mul_exp, mul_frac, s2_zero);
		end else if (v3) begin
			y <= pack(s3_sign, s3_exp, s3_frac, s3_zero);
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
			done <= 1'b0;
		end else begin
			v1 <= start;
			v2 <= v1;
			v3 <= v2 && (op_q == arith_pkg::fp_add);
			done <= (v2 && (op_q == arith_pkg::fp_mul)) || v3;
		end
	end

	a_start_idle: assert property (@(posedge CLK) disable iff (reset) start |-> !(v1 || v2 || v3))
		else $error("FPU start while an operation is running");

endmodule

`default_nettype wire

//--- execution/alu.sv
`default_nettype none

module alu (
	input arith_pkg::alu_op_e op,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] y
);
	logic [4:0] shamt;

	assign shamt = a[4:0];

	always_comb begin
		case (op)
			arith_pkg::alu_add: y = a + b;
			arith_pkg::alu_sub: y = a - b;
			arith_pkg::alu_and: y = a & b;
			arith_pkg::alu_or: y = a | b;
			arith_pkg::alu_xor: y = a ^ b;
			arith_pkg::alu_nor: y = ~(a | b);
			arith_pkg::alu_slt: y = {31'd0, $signed(a) < $signed(b)};
			arith_pkg::alu_sll: y = b << shamt;
			arith_pkg::alu_srl: y = b >> shamt;
			arith_pkg::alu_sra: y = $signed(b) >>> shamt;
			arith_pkg::alu_lui: y = b << 16;
			default: y = a + b;
		endcase
	end

endmodule

`default_nettype wire

//--- execution/operand_select.sv
`default_nettype none

module operand_select (
	input stage_pkg::issue_t dec,
	output logic [31:0] op1,
	output logic [31:0] op2,
	output logic [4:0] dest
);
	logic [31:0] sel2;

	always_comb begin
		case (dec.ctrl.src2_sel)
			stage_pkg::src2_rt: sel2 = dec.rt_val;
			stage_pkg::src2_sa: sel2 = {27'd0, dec.sa};
			stage_pkg::src2_simm: sel2 = {{16{dec.immediate[15]}}, dec.immediate};
			default: sel2 = {16'd0, dec.immediate};
		endcase

		// Shifts put the amount on op1 and the rt data on op2
		if (dec.ctrl.src1_sel) begin
			op1 = sel2;
			op2 = dec.rt_val;
		end else begin
			op1 = dec.rs_val;
			op2 = sel2;
		end

		case (dec.ctrl.dest_sel)
			stage_pkg::dest_rd: dest = dec.rd;
			stage_pkg::dest_rt: dest = dec.rt;
			stage_pkg::dest_link: dest = 5'd31;
			default: dest = dec.sa;
		endcase
	end

endmodule

`default_nettype wire

//--- design/decoder.sv
`default_nettype none

module decoder #(
	parameter int pc_width = 5
) (
	input logic [31:0] instr,
	input logic [31:0] rs_val,
	input logic [31:0] rt_val,
	output stage_pkg::issue_t dec
);
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_jal = 6'h03;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_addi = 6'h08;
	localparam logic [5:0] op_andi = 6'h0c;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lui = 6'h0f;
	localparam logic [5:0] op_cop1 = 6'h11;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;

	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_srl = 6'h02;
	localparam logic [5:0] fn_sra = 6'h03;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_xor = 6'h26;
	localparam logic [5:0] fn_nor = 6'h27;
	localparam logic [5:0] fn_slt = 6'h2a;
	localparam logic [5:0] fn_fadd = 6'h00;
	localparam logic [5:0] fn_fmul = 6'h02;
	localparam logic [4:0] fmt_single = 5'd16;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [15:0] imm;
	stage_pkg::ctrl_t c;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		c = stage_pkg::ctrl_nop;
		imm = instr[15:0];
		case (opcode)
			op_rtype: begin
				c.reg_write = 1'b1;
				case (funct)
					fn_add: c.alu_op = arith_pkg::alu_add;
					fn_sub: c.alu_op = arith_pkg::alu_sub;
					fn_and: c.alu_op = arith_pkg::alu_and;
					fn_or: c.alu_op = arith_pkg::alu_or;
					fn_xor: c.alu_op = arith_pkg::alu_xor;
					fn_nor: c.alu_op = arith_pkg::alu_nor;
					fn_slt: c.alu_op = arith_pkg::alu_slt;
					fn_sll, fn_srl, fn_sra: begin
						// Amount from sa, data from rt
						c.src2_sel = stage_pkg::src2_sa;
						c.src1_sel = 1'b1;
						if (funct == fn_sll) begin
							c.alu_op = arith_pkg::alu_sll;
						end else if (funct == fn_srl) begin
							c.alu_op = arith_pkg::alu_srl;
						end else begin
							c.alu_op = arith_pkg::alu_sra;
						end
					end
					default: c.reg_write = 1'b0;
				endcase
			end
			op_addi, op_andi, op_ori, op_lui: begin
				c.reg_write = 1'b1;
				c.dest_sel = stage_pkg::dest_rt;
				c.src2_sel = stage_pkg::src2_zimm;
				if (opcode == op_addi) begin
					c.src2_sel = stage_pkg::src2_simm;
				end else if (opcode == op_andi) begin
					c.alu_op = arith_pkg::alu_and;
				end else if (opcode == op_ori) begin
					c.alu_op = arith_pkg::alu_or;
				end else begin
					c.alu_op = arith_pkg::alu_lui;
				end
			end
			op_lw: begin
				c.reg_write = 1'b1;
				c.mem_read = 1'b1;
				c.mem_to_reg = stage_pkg::wb_mem;
				c.dest_sel = stage_pkg::dest_rt;
				c.src2_sel = stage_pkg::src2_simm;
			end
			op_sw: begin
				c.mem_write = 1'b1;
				c.dest_sel = stage_pkg::dest_rt;
				c.src2_sel = stage_pkg::src2_simm;
			end
			op_beq: begin
				c.branch = stage_pkg::br_eq;
				c.alu_op = arith_pkg::alu_sub;
			end
			op_jal: begin
				c.reg_write = 1'b1;
				c.mem_to_reg = stage_pkg::wb_link;
				c.branch = stage_pkg::br_jump;
				c.dest_sel = stage_pkg::dest_link;
				// Jump offset kept within the instruction memory
				imm = 16'(instr[pc_width-1:0]);
			end
			op_cop1: begin
				if (instr[25:21] == fmt_single && (funct == fn_fadd || funct == fn_fmul)) begin
					c.reg_write = 1'b1;
					c.is_fp = 1'b1;
					c.dest_sel = stage_pkg::dest_fd;
					if (funct == fn_fmul) begin
						c.alu_op = arith_pkg::alu_op_e'(arith_pkg::fp_mul);
					end else begin
						c.alu_op = arith_pkg::alu_op_e'(arith_pkg::fp_add);
					end
				end
			end
			default: c = stage_pkg::ctrl_nop;
		endcase
	end

	assign dec = '{
		ctrl: c,
		rs_val: rs_val,
		rt_val: rt_val,
		rt: instr[20:16],
		rd: instr[15:11],
		sa: instr[10:6],
		immediate: imm,
		inst_index: instr[25:0]
	};

endmodule

`default_nettype wire

//--- common/stage_pkg.sv
`default_nettype none

package stage_pkg;

	// Branch field codes
	localparam logic [1:0] br_eq = 2'd0;
	localparam logic [1:0] br_jump = 2'd2;
	localparam logic [1:0] br_none = 2'd3;

	// Writeback source
	localparam logic [1:0] wb_alu = 2'd0;
	localparam logic [1:0] wb_mem = 2'd1;
	localparam logic [1:0] wb_link = 2'd2;

	// Operand 2 source
	localparam logic [1:0] src2_rt = 2'd0;
	localparam logic [1:0] src2_sa = 2'd1;
	localparam logic [1:0] src2_simm = 2'd2;
	localparam logic [1:0] src2_zimm = 2'd3;

	// Destination register
	localparam logic [1:0] dest_rd = 2'd0;
	localparam logic [1:0] dest_rt = 2'd1;
	localparam logic [1:0] dest_link = 2'd2;
	localparam logic [1:0] dest_fd = 2'd3;

	typedef struct packed {
		logic reg_write;
		logic [1:0] mem_to_reg;
		logic [1:0] branch;
		logic mem_write;
		logic mem_read;
		logic uart_to_reg;
		logic reg_to_uart;
		logic is_fp;
		logic [1:0] src2_sel;
		logic src1_sel;
		logic [1:0] dest_sel;
		arith_pkg::alu_op_e alu_op;
	} ctrl_t;

	// No-operation bundle with all writes off
	localparam ctrl_t ctrl_nop = '{
		alu_op: arith_pkg::alu_add,
		branch: br_none,
		mem_to_reg: wb_alu,
		src2_sel: src2_rt,
		dest_sel: dest_rd,
		default: '0
	};

	typedef struct packed {
		ctrl_t ctrl;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		logic [15:0] immediate;
		logic [25:0] inst_index;
	} issue_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [31:0] value;
		logic [31:0] store_data;
		logic [4:0] dest;
		logic [25:0] inst_index;
	} exec_result_t;

endpackage

`default_nettype wire

//--- common/arith_pkg.sv
`default_nettype none

package arith_pkg;

	// Integer ALU operations
	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_xor = 4'd4,
		alu_nor = 4'd5,
		alu_slt = 4'd6,
		alu_sll = 4'd7,
		alu_srl = 4'd8,
		alu_sra = 4'd9,
		alu_lui = 4'd10
	} alu_op_e;

	// FPU operations, carried in the low bit of the ALU op field
	typedef enum logic {
		fp_add = 1'b0,
		fp_mul = 1'b1
	} fp_op_e;

	// Single-precision field widths
	localparam int EXP_W = 8;
	localparam int MAN_W = 23;

endpackage

`default_nettype wire
